// ==== src/if_pkg.sv ====
// shared types and constants of the instruction-fetch stage
// boot and mtvec bases are expected to be aligned to 256 bytes
// only the low 5 bits of the exception cause feed the vector
package if_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // byte address and raw fetched word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // low half of the word, kept for the trap value
  typedef logic [15:0] instr_c_t;
  // interrupt number taken from the exception cause
  typedef logic [4:0]  irq_id_t;

  ////////////////////////////////////////
  // selects
  ////////////////////////////////////////

  // next fetch address source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector source
  typedef enum logic [2:0] {
    EXC_PC_EXC     = 3'd0,
    EXC_PC_IRQ     = 3'd1,
    EXC_PC_IRQ_X   = 3'd2,
    EXC_PC_DBD     = 3'd3,
    EXC_PC_DBG_EXC = 3'd4
  } exc_pc_sel_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // PC control from the core's controller
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [5:0]  exc_cause;
  } pc_ctrl_t;

  // CSR addresses the fetch stage can jump to
  typedef struct packed {
    addr_t mepc;
    addr_t depc;
    addr_t mtvec;
    addr_t mtvecx;
  } csr_pc_t;

  // word presented by the prefetch buffer
  typedef struct packed {
    instr_t rdata;
    addr_t  addr;
    logic   err;
    logic   err_plus2;
  } fetch_rsp_t;

  // contents of the IF-ID register
  typedef struct packed {
    instr_t   rdata;
    instr_c_t rdata_c;
    logic     is_compressed;
    logic     fetch_err;
    logic     fetch_err_plus2;
    addr_t    pc;
  } id_instr_t;

  // boot entry sits at this offset from the aligned base
  localparam logic [7:0]  BootOffset = 8'h80;
  // low address bits replaced by the vector
  localparam int unsigned VecAlign   = 8;
  // sequential increments for full and compressed words
  localparam addr_t       IncrFull   = 32'd4;
  localparam addr_t       IncrComp   = 32'd2;

endpackage

// ==== src/if_pc_select.sv ====
// next fetch address and exception vector selection, purely combinational
// the low VecAlign bits of boot_addr_i and of the mtvec bases are ignored
// bit 0 of the selected address is always forced low
module if_pc_select
  import if_pkg::*;
#(
  parameter addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  addr_t    boot_addr_i,
  input  pc_ctrl_t pc_ctrl_i,
  input  csr_pc_t  csr_pc_i,
  input  addr_t    branch_target_i,
  output addr_t    fetch_addr_o,
  output logic     branch_req_o,
  output logic     csr_mtvec_init_o
);

  irq_id_t irq_id;
  addr_t   exc_pc;
  addr_t   boot_pc;
  addr_t   next_pc;

  // interrupt number is the low part of the cause
  // MSB of the cause only marks irq vs exception
  assign irq_id = pc_ctrl_i.exc_cause[4:0];

  // boot entry on the aligned boot base
  assign boot_pc = {boot_addr_i[31:VecAlign], BootOffset};

  ////////////////////////////////////////
  // exception vector
  ////////////////////////////////////////

  always_comb begin
    unique case (pc_ctrl_i.exc_pc_mux)
      // synchronous trap lands on the base itself
      EXC_PC_EXC: begin
        exc_pc = {csr_pc_i.mtvec[31:VecAlign], {VecAlign{1'b0}}};
      end
      // vectored irq: base + 4 * id
      EXC_PC_IRQ: begin
        exc_pc = {csr_pc_i.mtvec[31:VecAlign], {(VecAlign - 7){1'b0}}, irq_id, 2'b00};
      end
      // extended irq uses its own base
      EXC_PC_IRQ_X: begin
        exc_pc = {csr_pc_i.mtvecx[31:VecAlign], {(VecAlign - 7){1'b0}}, irq_id, 2'b00};
      end
      // debug entry and debug exception
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default: begin
        exc_pc = {csr_pc_i.mtvec[31:VecAlign], {VecAlign{1'b0}}};
      end
    endcase
  end

  ////////////////////////////////////////
  // fetch address
  ////////////////////////////////////////

  always_comb begin
    unique case (pc_ctrl_i.pc_mux)
      PC_BOOT: next_pc = boot_pc;
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap
      PC_ERET: next_pc = csr_pc_i.mepc;
      // return from debug
      PC_DRET: next_pc = csr_pc_i.depc;
      default: next_pc = boot_pc;
    endcase
  end

  // halfword alignment toward the prefetch buffer
  assign fetch_addr_o = {next_pc[31:1], 1'b0};

  // every PC set redirects the prefetch buffer
  assign branch_req_o = pc_ctrl_i.pc_set;

  // mtvec gets initialised on the boot jump
  assign csr_mtvec_init_o = pc_ctrl_i.pc_set & (pc_ctrl_i.pc_mux == PC_BOOT);

endmodule

// ==== src/if_id_pipe.sv ====
// IF-ID pipeline register with valid and new flags
// a word is accepted when fetch_valid_i and id_in_ready_i are both high
// data fields are undefined until the first acceptance
module if_id_pipe
  import if_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // prefetch buffer side
  input  logic       fetch_valid_i,
  input  fetch_rsp_t fetch_rsp_i,
  output logic       fetch_ready_o,
  // controller side
  input  logic       id_in_ready_i,
  input  logic       pc_set_i,
  input  logic       instr_valid_clear_i,
  // register write enable, seen by the PC checker
  output logic       fetch_accept_o,
  // ID stage side
  output logic       instr_valid_id_o,
  output logic       instr_new_id_o,
  output id_instr_t  id_instr_o
);

  logic      fetch_accept;
  logic      valid_d;
  logic      valid_q;
  logic      new_d;
  logic      new_q;
  id_instr_t id_instr_d;
  id_instr_t id_instr_q;

  // ID back-pressure goes straight back to the buffer
  assign fetch_ready_o = id_in_ready_i;
  assign fetch_accept  = fetch_valid_i & id_in_ready_i;

  ////////////////////////////////////////
  // flags
  ////////////////////////////////////////

  // a PC set in the same cycle squashes the incoming word
  // valid otherwise holds until cleared by the controller
  assign valid_d = (fetch_accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);
  // new marks exactly the cycle after an acceptance
  assign new_d   = fetch_accept;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
    end
  end

  ////////////////////////////////////////
  // data
  ////////////////////////////////////////

  always_comb begin
    id_instr_d.rdata           = fetch_rsp_i.rdata;
    id_instr_d.rdata_c         = fetch_rsp_i.rdata[15:0];
    // RVC words are those whose two low bits are not 2'b11
    id_instr_d.is_compressed   = (fetch_rsp_i.rdata[1:0] != 2'b11);
    id_instr_d.fetch_err       = fetch_rsp_i.err;
    id_instr_d.fetch_err_plus2 = fetch_rsp_i.err_plus2;
    id_instr_d.pc              = fetch_rsp_i.addr;
  end

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (fetch_accept) begin
      id_instr_q <= id_instr_d;
    end
  end

  assign fetch_accept_o   = fetch_accept;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign id_instr_o       = id_instr_q;

endmodule

// ==== src/if_pc_check.sv ====
// PC sequence hardening, alerts when a sequential word is not at pc + 2/4
// the first word after reset or after any branch request is not checked
module if_pc_check
  import if_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // word currently presented by the prefetch buffer
  input  logic  fetch_valid_i,
  input  addr_t fetch_addr_i,
  // IF-ID write enable and redirect
  input  logic  fetch_accept_i,
  input  logic  branch_req_i,
  // last accepted word
  input  addr_t pc_id_i,
  input  logic  is_compressed_id_i,
  output logic  pc_mismatch_alert_o
);

  logic  seq_d;
  logic  seq_q;
  addr_t pc_expected;

  // set by an acceptance, cleared by any redirect
  // the clear wins when both happen together
  assign seq_d = (seq_q | fetch_accept_i) & ~branch_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  // address the next word should come from
  assign pc_expected = pc_id_i + (is_compressed_id_i ? IncrComp : IncrFull);

  // only meaningful while a word is on offer
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_addr_i != pc_expected);

endmodule

// ==== src/if_stage.sv ====
// instruction-fetch stage top level
// the prefetch buffer sits outside and presents one word at a time
// boot_addr_i and the mtvec bases are assumed 256-byte aligned
// fetch_ready_o follows id_in_ready_i, no extra handshake
module if_stage
  import if_pkg::*;
#(
  parameter addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // target selection inputs
  input  addr_t      boot_addr_i,
  input  pc_ctrl_t   pc_ctrl_i,
  input  csr_pc_t    csr_pc_i,
  input  addr_t      branch_target_i,
  // prefetch buffer
  output addr_t      fetch_addr_o,
  output logic       branch_req_o,
  input  logic       fetch_valid_i,
  input  fetch_rsp_t fetch_rsp_i,
  output logic       fetch_ready_o,
  // CSR file
  output logic       csr_mtvec_init_o,
  // ID stage
  input  logic       id_in_ready_i,
  input  logic       instr_valid_clear_i,
  output logic       instr_valid_id_o,
  output logic       instr_new_id_o,
  output id_instr_t  id_instr_o,
  // misc
  output addr_t      pc_if_o,
  output logic       pc_mismatch_alert_o
);

  addr_t     fetch_addr;
  logic      branch_req;
  logic      fetch_accept;
  id_instr_t id_instr;

  ////////////////////////////////////////
  // target selection
  ////////////////////////////////////////

  if_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .boot_addr_i      (boot_addr_i),
    .pc_ctrl_i        (pc_ctrl_i),
    .csr_pc_i         (csr_pc_i),
    .branch_target_i  (branch_target_i),
    .fetch_addr_o     (fetch_addr),
    .branch_req_o     (branch_req),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ////////////////////////////////////////
  // IF-ID register
  ////////////////////////////////////////

  // pc_set squashes whatever is accepted alongside it
  if_id_pipe u_id_pipe (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_rsp_i         (fetch_rsp_i),
    .fetch_ready_o       (fetch_ready_o),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_ctrl_i.pc_set),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_accept_o      (fetch_accept),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr)
  );

  ////////////////////////////////////////
  // PC sequence check
  ////////////////////////////////////////

  // compares the presented word against the registered one
  if_pc_check u_pc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_addr_i        (fetch_rsp_i.addr),
    .fetch_accept_i      (fetch_accept),
    .branch_req_i        (branch_req),
    .pc_id_i             (id_instr.pc),
    .is_compressed_id_i  (id_instr.is_compressed),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  assign fetch_addr_o = fetch_addr;
  assign branch_req_o = branch_req;
  assign id_instr_o   = id_instr;
  // PC of the word currently in IF
  assign pc_if_o      = fetch_rsp_i.addr;

endmodule

// ==== tests/if_stage_checker.sv ====
// concurrent assertions on the fetch stage ports, bound into if_stage
// boot alignment is judged on the boot base input during the boot jump
module if_stage_checker
  import if_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input addr_t      boot_addr_i,
  input pc_ctrl_t   pc_ctrl_i,
  input logic       csr_mtvec_init_o,
  input logic       fetch_valid_i,
  input fetch_rsp_t fetch_rsp_i
);

  // boot base handed in must already be 256-byte aligned
  a_boot_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o |-> (boot_addr_i[VecAlign-1:0] == '0))
    else $error("boot base address is not aligned to 256 bytes");

  // error flags only come along with a presented word
  a_err_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_rsp_i.err | fetch_rsp_i.err_plus2) |-> fetch_valid_i)
    else $error("fetch error flag raised without a valid word");

  // both selects known whenever the PC gets set
  a_mux_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_ctrl_i.pc_set |-> !$isunknown({pc_ctrl_i.pc_mux, pc_ctrl_i.exc_pc_mux}))
    else $error("PC mux select is unknown during a PC set");

endmodule

bind if_stage if_stage_checker u_checker (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .boot_addr_i      (boot_addr_i),
  .pc_ctrl_i        (pc_ctrl_i),
  .csr_mtvec_init_o (csr_mtvec_init_o),
  .fetch_valid_i    (fetch_valid_i),
  .fetch_rsp_i      (fetch_rsp_i)
);

// ==== tests/tb_if_stage.sv ====
// table-driven testbench of the fetch stage, expected values come from a small model
// debug addresses are overridden here, random values use one fixed seed
module tb_if_stage
  import if_pkg::*;
();

  localparam addr_t    HaltAddr  = 32'h0002_0800;
  localparam addr_t    ExcAddr   = 32'h0002_0808;
  localparam int       NumRows   = 20;
  localparam int       MaxCycles = NumRows + 16 + 20;
  localparam pc_ctrl_t NoSet     = '0;

  // one cycle of stimulus plus what the DUT should answer
  typedef struct packed {
    pc_ctrl_t   ctrl;
    logic       fv;
    fetch_rsp_t rsp;
    logic       rdy;
    logic       clr;
    addr_t      addr;
    logic       br;
    logic       init;
    logic       alert;
    logic       valid;
    logic       new_f;
    logic       have;
    id_instr_t  word;
  } row_t;

  logic       clk_i;
  logic       rst_ni;
  addr_t      boot_addr;
  pc_ctrl_t   pc_ctrl;
  csr_pc_t    csr_pc;
  addr_t      target;
  logic       fetch_valid;
  fetch_rsp_t fetch_rsp;
  logic       id_ready;
  logic       valid_clear;
  addr_t      fetch_addr;
  logic       branch_req;
  logic       fetch_ready;
  logic       mtvec_init;
  logic       instr_valid;
  logic       instr_new;
  id_instr_t  id_instr;
  addr_t      pc_if;
  logic       alert;

  row_t       rows [NumRows];
  int         n_rows;
  int         cycles = 0;
  // model of the sequence flag, valid flag and last accepted word
  logic       m_seq;
  logic       m_valid;
  logic       m_have;
  id_instr_t  m_word;

  if_stage #(
    .DmHaltAddr      (HaltAddr),
    .DmExceptionAddr (ExcAddr)
  ) uut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr),
    .pc_ctrl_i           (pc_ctrl),
    .csr_pc_i            (csr_pc),
    .branch_target_i     (target),
    .fetch_addr_o        (fetch_addr),
    .branch_req_o        (branch_req),
    .fetch_valid_i       (fetch_valid),
    .fetch_rsp_i         (fetch_rsp),
    .fetch_ready_o       (fetch_ready),
    .csr_mtvec_init_o    (mtvec_init),
    .id_in_ready_i       (id_ready),
    .instr_valid_clear_i (valid_clear),
    .instr_valid_id_o    (instr_valid),
    .instr_new_id_o      (instr_new),
    .id_instr_o          (id_instr),
    .pc_if_o             (pc_if),
    .pc_mismatch_alert_o (alert)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_instr(input string name, input id_instr_t got, input id_instr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // hard stop in case the table never completes
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      fail_run("the run did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////
  // reference model and table
  ////////////////////////////////////////

  function automatic addr_t target_of(input pc_ctrl_t c);
    addr_t vec;
    addr_t pc;
    case (c.exc_pc_mux)
      EXC_PC_IRQ:     vec = (csr_pc.mtvec & 32'hFFFF_FF00) + 4 * c.exc_cause[4:0];
      EXC_PC_IRQ_X:   vec = (csr_pc.mtvecx & 32'hFFFF_FF00) + 4 * c.exc_cause[4:0];
      EXC_PC_DBD:     vec = HaltAddr;
      EXC_PC_DBG_EXC: vec = ExcAddr;
      default:        vec = csr_pc.mtvec & 32'hFFFF_FF00;
    endcase
    case (c.pc_mux)
      PC_JUMP: pc = target;
      PC_EXC:  pc = vec;
      PC_ERET: pc = csr_pc.mepc;
      PC_DRET: pc = csr_pc.depc;
      default: pc = (boot_addr & 32'hFFFF_FF00) + 32'h80;
    endcase
    return pc & ~32'h1;
  endfunction

  function automatic pc_ctrl_t ctl(input logic set, input pc_sel_e mux,
                                   input exc_pc_sel_e exc, input logic [5:0] cause);
    pc_ctrl_t c;
    c.pc_set     = set;
    c.pc_mux     = mux;
    c.exc_pc_mux = exc;
    c.exc_cause  = cause;
    return c;
  endfunction

  // random word at an address, low bits pick full or compressed
  function automatic fetch_rsp_t word_at(input addr_t a, input logic comp,
                                         input logic e, input logic e2);
    fetch_rsp_t r;
    r.rdata      = $urandom;
    r.rdata[1:0] = comp ? 2'b01 : 2'b11;
    r.addr       = a;
    r.err        = e;
    r.err_plus2  = e2;
    return r;
  endfunction

  task automatic add_row(input pc_ctrl_t ctrl, input logic fv, input fetch_rsp_t rsp,
                         input logic rdy, input logic clr);
    row_t  r;
    logic  acc;
    addr_t next_pc;
    acc     = fv & rdy;
    next_pc = m_word.pc + ((m_word.rdata[1:0] != 2'b11) ? 32'd2 : 32'd4);
    r.ctrl  = ctrl;
    r.fv    = fv;
    r.rsp   = rsp;
    r.rdy   = rdy;
    r.clr   = clr;
    r.addr  = target_of(ctrl);
    r.br    = ctrl.pc_set;
    r.init  = ctrl.pc_set && (ctrl.pc_mux == PC_BOOT);
    // only a word following an accepted one without redirect gets checked
    r.alert = m_seq && fv && (rsp.addr != next_pc);
    if (acc) begin
      m_word.rdata           = rsp.rdata;
      m_word.rdata_c         = rsp.rdata[15:0];
      m_word.is_compressed   = (rsp.rdata[1:0] != 2'b11);
      m_word.fetch_err       = rsp.err;
      m_word.fetch_err_plus2 = rsp.err_plus2;
      m_word.pc              = rsp.addr;
      m_have                 = 1'b1;
    end
    if (ctrl.pc_set) begin
      m_seq = 1'b0;
    end else if (acc) begin
      m_seq = 1'b1;
    end
    if (acc && !ctrl.pc_set) begin
      m_valid = 1'b1;
    end else if (clr) begin
      m_valid = 1'b0;
    end
    r.valid = m_valid;
    r.new_f = acc;
    r.have  = m_have;
    r.word  = m_word;
    rows[n_rows] = r;
    n_rows = n_rows + 1;
  endtask

  task automatic build_table();
    addr_t      boot_pc;
    addr_t      a;
    fetch_rsp_t held;
    boot_pc = (boot_addr & 32'hFFFF_FF00) + 32'h80;
    n_rows  = 0;
    // boot jump, then a straight run of full and compressed words
    add_row(ctl(1, PC_BOOT, EXC_PC_EXC, 0), 0, '0, 1, 0);
    add_row(NoSet, 1, word_at(boot_pc, 0, 0, 0), 1, 0);
    add_row(NoSet, 1, word_at(boot_pc + 4, 1, 0, 0), 1, 0);
    add_row(NoSet, 1, word_at(boot_pc + 6, 0, 1, 0), 1, 0);
    // ID stalls with a word on offer, then takes it
    a    = boot_pc + 10;
    held = word_at(a, 1, 0, 0);
    add_row(NoSet, 1, held, 0, 0);
    add_row(NoSet, 1, held, 1, 0);
    // out of sequence word, then valid clear
    add_row(NoSet, 1, word_at(a + 8, 0, 0, 0), 1, 0);
    add_row(NoSet, 0, '0, 1, 1);
    // word squashed by a jump, the next one goes unchecked
    add_row(ctl(1, PC_JUMP, EXC_PC_EXC, 0), 1, word_at(a + 12, 0, 0, 0), 1, 0);
    add_row(NoSet, 1, word_at(target & ~32'h1, 0, 0, 0), 1, 0);
    // exception vectors and trap returns
    add_row(ctl(1, PC_EXC, EXC_PC_EXC, 6'h0B), 0, '0, 1, 0);
    add_row(ctl(1, PC_EXC, EXC_PC_IRQ, 6'h27), 0, '0, 1, 0);
    add_row(ctl(1, PC_EXC, EXC_PC_IRQ_X, 6'h3F), 0, '0, 1, 0);
    add_row(ctl(1, PC_EXC, EXC_PC_DBD, 0), 0, '0, 1, 0);
    add_row(ctl(1, PC_EXC, EXC_PC_DBG_EXC, 0), 0, '0, 1, 0);
    add_row(ctl(1, PC_ERET, EXC_PC_EXC, 0), 0, '0, 1, 0);
    add_row(ctl(1, PC_DRET, EXC_PC_EXC, 0), 0, '0, 1, 0);
    // jump select without pc_set is no branch
    add_row(ctl(0, PC_JUMP, EXC_PC_EXC, 0), 0, '0, 1, 0);
    add_row(NoSet, 1, word_at(csr_pc.depc & ~32'h1, 1, 0, 1), 1, 0);
    add_row(NoSet, 0, '0, 1, 1);
  endtask

  ////////////////////////////////////////
  // apply and check
  ////////////////////////////////////////

  task automatic check_now(input row_t r);
    check_addr("fetch_addr_o", fetch_addr, r.addr);
    check_bit("branch_req_o", branch_req, r.br);
    check_bit("csr_mtvec_init_o", mtvec_init, r.init);
    check_bit("pc_mismatch_alert_o", alert, r.alert);
    check_bit("fetch_ready_o", fetch_ready, r.rdy);
    check_addr("pc_if_o", pc_if, r.rsp.addr);
  endtask

  // registered results, one edge after the row
  task automatic check_next(input row_t r);
    check_bit("instr_valid_id_o", instr_valid, r.valid);
    check_bit("instr_new_id_o", instr_new, r.new_f);
    if (r.have) begin
      check_instr("id_instr_o", id_instr, r.word);
    end
  endtask

  initial begin
    void'($urandom(32'h989d00e8));
    rst_ni      = 1'b0;
    boot_addr   = $urandom & 32'hFFFF_FF00;
    csr_pc.mepc   = $urandom;
    csr_pc.depc   = $urandom;
    csr_pc.mtvec  = $urandom & 32'hFFFF_FF00;
    csr_pc.mtvecx = $urandom & 32'hFFFF_FF00;
    target      = $urandom;
    pc_ctrl     = NoSet;
    fetch_valid = 1'b0;
    fetch_rsp   = '0;
    id_ready    = 1'b0;
    valid_clear = 1'b0;
    m_seq       = 1'b0;
    m_valid     = 1'b0;
    m_have      = 1'b0;
    build_table();
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    check_bit("instr_valid_id_o", instr_valid, 1'b0);
    check_bit("instr_new_id_o", instr_new, 1'b0);
    check_bit("pc_mismatch_alert_o", alert, 1'b0);
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk_i);
      #1;
      if (i > 0) begin
        check_next(rows[i - 1]);
      end
      pc_ctrl     = rows[i].ctrl;
      fetch_valid = rows[i].fv;
      fetch_rsp   = rows[i].rsp;
      id_ready    = rows[i].rdy;
      valid_clear = rows[i].clr;
      #7;
      check_now(rows[i]);
    end
    @(posedge clk_i);
    #1;
    check_next(rows[n_rows - 1]);
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== project.f ====
src/if_pkg.sv
src/if_pc_select.sv
src/if_id_pipe.sv
src/if_pc_check.sv
src/if_stage.sv
tests/if_stage_checker.sv
tests/tb_if_stage.sv
